// File: Bender.yml
package:
  name: pmu

sources:
  # Packages first, the modules import them
  - source/pmu_cfg_pkg.sv
  - source/pmu_map_pkg.sv
  # RTL
  - source/pmu_control.sv
  - source/pmu_event_route.sv
  - source/pmu_counters.sv
  - source/pmu_overflow.sv
  - source/pmu_quota.sv
  - source/pmu_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_pmu.sv

// File: source/pmu_cfg_pkg.sv
/*
 * Shared widths, limits and vector types of the PMU datapath.
 * Imported by every module that carries register words, selectors or sums.
 */

`default_nettype none

package pmu_cfg_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    // Register map packs fixed fields, so the width is fixed too
    localparam int REG_WIDTH      = 32;
    // Largest counter count the address map has room for
    localparam int MAX_COUNTERS   = 16;
    localparam int DEF_N_COUNTERS = 9;
    localparam int DEF_N_SOC_EV   = 32;

    // Selector wide enough to pick any of the default events
    localparam int EV_SEL_W = $clog2(DEF_N_SOC_EV);
    // Room for MAX_COUNTERS full counters added together
    localparam int SUM_W    = REG_WIDTH + $clog2(MAX_COUNTERS);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [REG_WIDTH-1:0] reg_word_t;
    typedef logic [EV_SEL_W-1:0]  ev_sel_t;
    typedef logic [SUM_W-1:0]     sum_t;

endpackage

`default_nettype wire

// File: source/pmu_control.sv
/*
 * PMU register file. Holds config, masks, limit and crossbar selectors,
 * returns read data combinationally and turns counter writes into
 * one-hot load strobes for the counter bank.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_control import pmu_cfg_pkg::*, pmu_map_pkg::*; #(
    parameter int N_COUNTERS = DEF_N_COUNTERS
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire                   reg_we_i,
    input  reg_addr_t             reg_addr_i,
    input  reg_word_t             reg_wdata_i,
    output reg_word_t             reg_rdata_o,
    input  reg_word_t             cnt_val_i [0:N_COUNTERS-1],
    input  wire  [N_COUNTERS-1:0] ovf_vect_i,
    output logic                  cnt_en_o,
    output logic                  cnt_softrst_o,
    output logic                  ovf_en_o,
    output logic                  ovf_softrst_o,
    output logic                  quota_softrst_o,
    output selftest_e             selftest_o,
    output ev_sel_t               xbar_sel_o [0:N_COUNTERS-1],
    output logic [N_COUNTERS-1:0] ovf_mask_o,
    output logic [N_COUNTERS-1:0] quota_mask_o,
    output reg_word_t             quota_limit_o,
    output logic [N_COUNTERS-1:0] cnt_we_o,
    output reg_word_t             cnt_wdata_o
);

    reg_word_t             cfg_q;
    logic [N_COUNTERS-1:0] ovf_mask_q;
    logic [N_COUNTERS-1:0] quota_mask_q;
    reg_word_t             quota_limit_q;
    ev_sel_t               xbar_sel_q [0:N_COUNTERS-1];

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            for (int k = 0; k < N_COUNTERS; k++) begin
                xbar_sel_q[k] <= '0;
            end
        end else if (reg_we_i) begin
            case (reg_addr_i)
                ADDR_CFG:         cfg_q         <= reg_wdata_i;
                ADDR_OVF_MASK:    ovf_mask_q    <= reg_wdata_i[N_COUNTERS-1:0];
                ADDR_QUOTA_MASK:  quota_mask_q  <= reg_wdata_i[N_COUNTERS-1:0];
                ADDR_QUOTA_LIMIT: quota_limit_q <= reg_wdata_i;
                default: ;
            endcase
            // Selectors keep only the low field of the word
            for (int k = 0; k < N_COUNTERS; k++) begin
                if (reg_addr_i == reg_addr_t'(ADDR_XBAR_BASE + k)) begin
                    xbar_sel_q[k] <= reg_wdata_i[EV_SEL_W-1:0];
                end
            end
        end
    end

    // Config fields straight from the register, one cycle after the write
    assign cnt_en_o        = cfg_q[CFG_EN_BIT];
    assign cnt_softrst_o   = cfg_q[CFG_SOFTRST_BIT];
    assign ovf_en_o        = cfg_q[CFG_OVF_EN_BIT];
    assign ovf_softrst_o   = cfg_q[CFG_OVF_SOFTRST_BIT];
    assign quota_softrst_o = cfg_q[CFG_QUOTA_SOFTRST_BIT];
    assign selftest_o      = selftest_e'(cfg_q[CFG_SELFTEST_LSB +: 2]);

    assign ovf_mask_o    = ovf_mask_q;
    assign quota_mask_o  = quota_mask_q;
    assign quota_limit_o = quota_limit_q;
    assign xbar_sel_o    = xbar_sel_q;

    // ------------------------------
    // Counter load strobes
    // ------------------------------
    // Pulse only in the write cycle, the counter bank loads on that edge
    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            cnt_we_o[k] = reg_we_i && (reg_addr_i == reg_addr_t'(ADDR_CNT_BASE + k));
        end
    end

    assign cnt_wdata_o = reg_wdata_i;

    // ------------------------------
    // Read multiplexer
    // ------------------------------
    // Unmapped addresses fall through to zero
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            ADDR_CFG:         reg_rdata_o = cfg_q;
            ADDR_OVF_MASK:    reg_rdata_o[N_COUNTERS-1:0] = ovf_mask_q;
            ADDR_OVF_VECT:    reg_rdata_o[N_COUNTERS-1:0] = ovf_vect_i;
            ADDR_QUOTA_MASK:  reg_rdata_o[N_COUNTERS-1:0] = quota_mask_q;
            ADDR_QUOTA_LIMIT: reg_rdata_o = quota_limit_q;
            default: ;
        endcase
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (reg_addr_i == reg_addr_t'(ADDR_XBAR_BASE + k)) begin
                reg_rdata_o[EV_SEL_W-1:0] = xbar_sel_q[k];
            end
            if (reg_addr_i == reg_addr_t'(ADDR_CNT_BASE + k)) begin
                reg_rdata_o = cnt_val_i[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pmu_counters.sv
/*
 * Bank of event counters. Each counter adds one per routed event while
 * enabled, loads a bus write, clears on soft reset and pulses its wrap
 * bit on the edge where it rolls over from all ones to zero.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_counters import pmu_cfg_pkg::*; #(
    parameter int N_COUNTERS = DEF_N_COUNTERS
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire                   en_i,
    input  wire                   softrst_i,
    input  wire  [N_COUNTERS-1:0] we_i,
    input  reg_word_t             wdata_i,
    input  wire  [N_COUNTERS-1:0] events_i,
    output reg_word_t             cnt_o [0:N_COUNTERS-1],
    output logic [N_COUNTERS-1:0] wrap_o
);

    reg_word_t             cnt_q [0:N_COUNTERS-1];
    logic [N_COUNTERS-1:0] wrap_q;

    // Priority is soft reset, then bus load, then increment
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wrap_q <= '0;
            for (int k = 0; k < N_COUNTERS; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                wrap_q[k] <= 1'b0;
                if (softrst_i) begin
                    cnt_q[k] <= '0;
                end else if (we_i[k]) begin
                    cnt_q[k] <= wdata_i;
                end else if (en_i && events_i[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                    // Rollover, wrap lines up with the zero value
                    wrap_q[k] <= &cnt_q[k];
                end
            end
        end
    end

    assign cnt_o  = cnt_q;
    assign wrap_o = wrap_q;

endmodule

`default_nettype wire

// File: source/pmu_event_route.sv
/*
 * Event crossbar. Each counter picks one SoC event by its selector,
 * the self-test mode may override the result, and the vector is
 * registered before it reaches the counters.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_event_route import pmu_cfg_pkg::*, pmu_map_pkg::*; #(
    parameter int N_COUNTERS = DEF_N_COUNTERS,
    parameter int N_SOC_EV   = DEF_N_SOC_EV
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire  [N_SOC_EV-1:0]   events_i,
    input  ev_sel_t               xbar_sel_i [0:N_COUNTERS-1],
    input  selftest_e             selftest_i,
    output logic [N_COUNTERS-1:0] routed_o
);

    logic [N_COUNTERS-1:0] xbar_ev;
    logic [N_COUNTERS-1:0] routed_d;
    logic [N_COUNTERS-1:0] routed_q;

    // One mux per counter
    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            // Selector beyond the event range picks nothing
            if (xbar_sel_i[k] < N_SOC_EV) begin
                xbar_ev[k] = events_i[xbar_sel_i[k]];
            end else begin
                xbar_ev[k] = 1'b0;
            end
        end
    end

    // Self-test override
    always_comb begin
        case (selftest_i)
            ST_ALL_ACTIVE: routed_d = '1;
            ST_ALL_OFF:    routed_d = '0;
            ST_ONE_ON:     routed_d = N_COUNTERS'(1);
            default:       routed_d = xbar_ev;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            routed_q <= '0;
        end else begin
            routed_q <= routed_d;
        end
    end

    assign routed_o = routed_q;

endmodule

`default_nettype wire

// File: source/pmu_map_pkg.sv
/*
 * Register map of the PMU: addresses, config bit fields, self-test modes.
 * Imported by the register file and by modules that decode the mode.
 */

`default_nettype none

package pmu_map_pkg;

    typedef logic [5:0] reg_addr_t;

    // ------------------------------
    // Register addresses
    // ------------------------------
    localparam reg_addr_t ADDR_CFG         = 6'd0;
    localparam reg_addr_t ADDR_OVF_MASK    = 6'd1;
    // Read only, driven by the overflow block
    localparam reg_addr_t ADDR_OVF_VECT    = 6'd2;
    localparam reg_addr_t ADDR_QUOTA_MASK  = 6'd3;
    localparam reg_addr_t ADDR_QUOTA_LIMIT = 6'd4;
    // One selector per counter, k at base+k
    localparam reg_addr_t ADDR_XBAR_BASE   = 6'd16;
    // One counter value per counter, k at base+k
    localparam reg_addr_t ADDR_CNT_BASE    = 6'd32;

    // Config register fields
    localparam int CFG_EN_BIT            = 0;
    localparam int CFG_SOFTRST_BIT       = 1;
    localparam int CFG_OVF_EN_BIT        = 2;
    localparam int CFG_OVF_SOFTRST_BIT   = 3;
    localparam int CFG_QUOTA_SOFTRST_BIT = 4;
    // Two bit field, 31:30
    localparam int CFG_SELFTEST_LSB      = 30;

    // Self-test override of the routed events
    typedef enum logic [1:0] {
        ST_OFF        = 2'd0,
        ST_ALL_ACTIVE = 2'd1,
        ST_ALL_OFF    = 2'd2,
        ST_ONE_ON     = 2'd3
    } selftest_e;

endpackage

`default_nettype wire

// File: source/pmu_overflow.sv
/*
 * Overflow tracking. Wrap pulses set sticky bits while enabled, only the
 * overflow soft reset clears them, and the masked vector is ORed into
 * one registered interrupt line.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_overflow #(
    parameter int N_COUNTERS = 9
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire                   en_i,
    input  wire                   softrst_i,
    input  wire  [N_COUNTERS-1:0] wrap_i,
    input  wire  [N_COUNTERS-1:0] mask_i,
    output logic [N_COUNTERS-1:0] vect_o,
    output logic                  intr_overflow_o
);

    logic [N_COUNTERS-1:0] vect_d;
    logic [N_COUNTERS-1:0] vect_q;
    logic                  intr_q;

    // Next vector, so the interrupt follows the wrap by a single cycle
    assign vect_d = softrst_i ? '0 : (vect_q | (en_i ? wrap_i : '0));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vect_q <= '0;
            intr_q <= 1'b0;
        end else begin
            vect_q <= vect_d;
            intr_q <= |(vect_d & mask_i);
        end
    end

    assign vect_o          = vect_q;
    assign intr_overflow_o = intr_q;

endmodule

`default_nettype wire

// File: source/pmu_quota.sv
/*
 * Quota check. Adds up the counters picked by the mask and raises a
 * registered interrupt while the sum is above the programmed limit.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_quota import pmu_cfg_pkg::*; #(
    parameter int N_COUNTERS = DEF_N_COUNTERS
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire                   softrst_i,
    input  reg_word_t             cnt_i [0:N_COUNTERS-1],
    input  wire  [N_COUNTERS-1:0] mask_i,
    input  reg_word_t             limit_i,
    output logic                  intr_quota_o
);

    sum_t sum_d;
    logic intr_q;

    // Masked sum, wide enough that it never wraps
    always_comb begin
        sum_d = '0;
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (mask_i[k]) begin
                sum_d = sum_d + sum_t'(cnt_i[k]);
            end
        end
    end

    // Strictly above the limit, equal does not fire
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            intr_q <= 1'b0;
        end else if (softrst_i) begin
            intr_q <= 1'b0;
        end else begin
            intr_q <= (sum_d > sum_t'(limit_i));
        end
    end

    assign intr_quota_o = intr_q;

endmodule

`default_nettype wire

// File: source/pmu_top.sv
/*
 * PMU top level. Connects the register file to the event crossbar,
 * counter bank, overflow and quota blocks. Sets the counter and event
 * counts for every block below it.
 */

`timescale 1ns/10ps
`default_nettype none

module pmu_top import pmu_cfg_pkg::*, pmu_map_pkg::*; #(
    parameter int N_COUNTERS = DEF_N_COUNTERS,
    parameter int N_SOC_EV   = DEF_N_SOC_EV
) (
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire                 reg_we_i,
    input  reg_addr_t           reg_addr_i,
    input  reg_word_t           reg_wdata_i,
    output reg_word_t           reg_rdata_o,
    input  wire  [N_SOC_EV-1:0] events_i,
    output logic                intr_overflow_o,
    output logic                intr_quota_o
);

    // ------------------------------
    // Control to datapath
    // ------------------------------
    logic                  cnt_en;
    logic                  cnt_softrst;
    logic                  ovf_en;
    logic                  ovf_softrst;
    logic                  quota_softrst;
    selftest_e             selftest;
    ev_sel_t               xbar_sel [0:N_COUNTERS-1];
    logic [N_COUNTERS-1:0] ovf_mask;
    logic [N_COUNTERS-1:0] quota_mask;
    reg_word_t             quota_limit;
    logic [N_COUNTERS-1:0] cnt_we;
    reg_word_t             cnt_wdata;

    // Datapath results
    logic [N_COUNTERS-1:0] routed;
    reg_word_t             cnt_val [0:N_COUNTERS-1];
    logic [N_COUNTERS-1:0] wrap;
    logic [N_COUNTERS-1:0] ovf_vect;

    pmu_control #(.N_COUNTERS(N_COUNTERS)) u_control (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .cnt_val_i       (cnt_val),
        .ovf_vect_i      (ovf_vect),
        .cnt_en_o        (cnt_en),
        .cnt_softrst_o   (cnt_softrst),
        .ovf_en_o        (ovf_en),
        .ovf_softrst_o   (ovf_softrst),
        .quota_softrst_o (quota_softrst),
        .selftest_o      (selftest),
        .xbar_sel_o      (xbar_sel),
        .ovf_mask_o      (ovf_mask),
        .quota_mask_o    (quota_mask),
        .quota_limit_o   (quota_limit),
        .cnt_we_o        (cnt_we),
        .cnt_wdata_o     (cnt_wdata)
    );

    // Events are registered once before counting
    pmu_event_route #(.N_COUNTERS(N_COUNTERS), .N_SOC_EV(N_SOC_EV)) u_event_route (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .events_i   (events_i),
        .xbar_sel_i (xbar_sel),
        .selftest_i (selftest),
        .routed_o   (routed)
    );

    pmu_counters #(.N_COUNTERS(N_COUNTERS)) u_counters (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (cnt_en),
        .softrst_i (cnt_softrst),
        .we_i      (cnt_we),
        .wdata_i   (cnt_wdata),
        .events_i  (routed),
        .cnt_o     (cnt_val),
        .wrap_o    (wrap)
    );

    pmu_overflow #(.N_COUNTERS(N_COUNTERS)) u_overflow (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .en_i            (ovf_en),
        .softrst_i       (ovf_softrst),
        .wrap_i          (wrap),
        .mask_i          (ovf_mask),
        .vect_o          (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota #(.N_COUNTERS(N_COUNTERS)) u_quota (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .softrst_i    (quota_softrst),
        .cnt_i        (cnt_val),
        .mask_i       (quota_mask),
        .limit_i      (quota_limit),
        .intr_quota_o (intr_quota_o)
    );

endmodule

`default_nettype wire

// File: test/tb_pmu.sv
/*
 * Self-checking testbench for the PMU top level at its default size.
 * Drives the register port and SoC events, checks reset values, routing,
 * self-test, counter load, overflow and quota through immediate assertions.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_pmu import pmu_cfg_pkg::*, pmu_map_pkg::*;;

    localparam int N_CNT = DEF_N_COUNTERS;
    localparam int N_EV  = DEF_N_SOC_EV;

    logic            clk_i;
    logic            rstn_i;
    logic            reg_we_i;
    reg_addr_t       reg_addr_i;
    reg_word_t       reg_wdata_i;
    reg_word_t       reg_rdata_o;
    logic [N_EV-1:0] events_i;
    logic            intr_overflow_o;
    logic            intr_quota_o;

    integer    seed;
    int        errors;
    int        errors_at_start;
    int        tests_passed;
    int        tests_failed;
    // Counter values before and after a window
    reg_word_t snap [0:1][0:N_CNT-1];

    pmu_top #(.N_COUNTERS(N_CNT), .N_SOC_EV(N_EV)) dut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    // 4 ns period
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------
    // Register map helpers
    // ------------------------------
    function automatic reg_word_t cfg_word(input logic en, input logic softrst,
                                           input logic ovf_en, input logic ovf_softrst,
                                           input logic quota_softrst, input selftest_e st);
        reg_word_t w;
        w                          = '0;
        w[CFG_EN_BIT]              = en;
        w[CFG_SOFTRST_BIT]         = softrst;
        w[CFG_OVF_EN_BIT]          = ovf_en;
        w[CFG_OVF_SOFTRST_BIT]     = ovf_softrst;
        w[CFG_QUOTA_SOFTRST_BIT]   = quota_softrst;
        w[CFG_SELFTEST_LSB +: 2]   = st;
        return w;
    endfunction

    function automatic reg_addr_t cnt_addr(input int k);
        return reg_addr_t'(ADDR_CNT_BASE + k);
    endfunction

    function automatic reg_addr_t xbar_addr(input int k);
        return reg_addr_t'(ADDR_XBAR_BASE + k);
    endfunction

    // Write lands on the second edge with the strobe high
    task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
        @(posedge clk_i);
        reg_we_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_we_i    <= 1'b0;
    endtask

    // Combinational read data sampled mid-cycle
    task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
        @(posedge clk_i);
        reg_addr_i <= addr;
        @(negedge clk_i);
        data = reg_rdata_o;
    endtask

    task automatic snapshot_counters(input int slot);
        for (int k = 0; k < N_CNT; k++) begin
            read_reg(cnt_addr(k), snap[slot][k]);
        end
    endtask

    // ------------------------------
    // Checks and bounded waits
    // ------------------------------
    task automatic check_eq(input reg_word_t got, input reg_word_t exp, input string what);
        assert (got === exp) else begin
            $display("** Error: time %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("** Error: time %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic wait_reg_equal(input reg_addr_t addr, input reg_word_t exp,
                                  input int max_cycles, input string what);
        reg_word_t val;
        int        n;
        logic      hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < max_cycles) begin
            read_reg(addr, val);
            hit = (val === exp);
            n++;
        end
        if (!hit) begin
            $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
            $display("Done: errors found");
            $finish;
        end
    endtask

    // quota_line picks the quota interrupt over the overflow one
    task automatic wait_intr_level(input logic quota_line, input logic level,
                                   input int max_cycles, input string what);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < max_cycles) begin
            @(negedge clk_i);
            hit = ((quota_line ? intr_quota_o : intr_overflow_o) === level);
            n++;
        end
        if (!hit) begin
            $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
            $display("Done: errors found");
            $finish;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL, %0d errors", name, errors - errors_at_start);
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        reg_word_t val;
        errors_at_start = errors;
        for (int k = 0; k < N_CNT; k++) begin
            read_reg(cnt_addr(k), val);
            check_eq(val, '0, $sformatf("counter %0d after reset", k));
        end
        read_reg(ADDR_CFG, val);
        check_eq(val, '0, "config after reset");
        read_reg(ADDR_OVF_MASK, val);
        check_eq(val, '0, "overflow mask after reset");
        read_reg(ADDR_OVF_VECT, val);
        check_eq(val, '0, "wrap vector after reset");
        read_reg(ADDR_QUOTA_MASK, val);
        check_eq(val, '0, "quota mask after reset");
        read_reg(ADDR_QUOTA_LIMIT, val);
        check_eq(val, '0, "quota limit after reset");
        check_true(!intr_overflow_o, "overflow interrupt high after reset");
        check_true(!intr_quota_o, "quota interrupt high after reset");
        finish_test("reset values");
    endtask

    task automatic test_crossbar();
        int              pulses [0:N_CNT-1];
        int              sel [0:N_CNT-1];
        logic [N_EV-1:0] pattern;
        reg_word_t       val;
        errors_at_start = errors;
        // Distinct event per counter
        // Last counter never sees a pulse
        for (int k = 0; k < N_CNT; k++) begin
            sel[k]    = (3 * k + 5) % N_EV;
            pulses[k] = (k == N_CNT - 1) ? 0 : 1 + ($unsigned($random(seed)) % 7);
            write_reg(xbar_addr(k), reg_word_t'(sel[k]));
        end
        write_reg(ADDR_CFG, cfg_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ST_OFF));
        // One-cycle pulses with a low cycle between them
        for (int i = 0; i < 7; i++) begin
            pattern = '0;
            for (int k = 0; k < N_CNT; k++) begin
                if (i < pulses[k]) begin
                    pattern[sel[k]] = 1'b1;
                end
            end
            @(posedge clk_i);
            events_i <= pattern;
            @(posedge clk_i);
            events_i <= '0;
        end
        // Drain the two-stage event pipe
        repeat (4) @(posedge clk_i);
        write_reg(ADDR_CFG, '0);
        for (int k = 0; k < N_CNT; k++) begin
            read_reg(cnt_addr(k), val);
            check_eq(val, reg_word_t'(pulses[k]), $sformatf("routed counter %0d", k));
        end
        finish_test("crossbar routing");
    endtask

    // Events held high where a pass-through would show up in the counts
    task automatic selftest_window(input selftest_e st, input logic en,
                                   input logic [N_EV-1:0] ev,
                                   input logic [N_CNT-1:0] grow);
        write_reg(ADDR_CFG, cfg_word(en, 1'b0, 1'b0, 1'b0, 1'b0, st));
        events_i <= ev;
        // Let the previous mode flush out
        repeat (3) @(posedge clk_i);
        snapshot_counters(0);
        repeat (8) @(posedge clk_i);
        snapshot_counters(1);
        for (int k = 0; k < N_CNT; k++) begin
            if (grow[k]) begin
                check_true(snap[1][k] > snap[0][k],
                           $sformatf("counter %0d did not grow in mode %s", k, st.name()));
            end else begin
                check_eq(snap[1][k], snap[0][k],
                         $sformatf("counter %0d in mode %s en %0b", k, st.name(), en));
            end
        end
    endtask

    task automatic test_selftest();
        errors_at_start = errors;
        selftest_window(ST_ALL_ACTIVE, 1'b1, '0, '1);
        selftest_window(ST_ONE_ON, 1'b1, '1, N_CNT'(1));
        selftest_window(ST_ALL_OFF, 1'b1, '1, '0);
        selftest_window(ST_ALL_ACTIVE, 1'b0, '1, '0);
        @(posedge clk_i);
        events_i <= '0;
        finish_test("self-test modes");
    endtask

    task automatic test_load_softrst();
        reg_word_t val;
        reg_word_t rnd;
        errors_at_start = errors;
        rnd = $random(seed);
        write_reg(ADDR_CFG, '0);
        write_reg(cnt_addr(3), 32'hDEAD_BEEF);
        write_reg(cnt_addr(6), rnd);
        read_reg(cnt_addr(3), val);
        check_eq(val, 32'hDEAD_BEEF, "loaded counter 3");
        read_reg(cnt_addr(6), val);
        check_eq(val, rnd, "loaded counter 6");
        write_reg(ADDR_CFG, cfg_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, ST_OFF));
        write_reg(ADDR_CFG, '0);
        for (int k = 0; k < N_CNT; k++) begin
            read_reg(cnt_addr(k), val);
            check_eq(val, '0, $sformatf("counter %0d after soft reset", k));
        end
        finish_test("load and soft reset");
    endtask

    task automatic test_overflow();
        reg_word_t val;
        errors_at_start = errors;
        // Three increments away from the wrap
        write_reg(cnt_addr(1), '1 - 2);
        write_reg(cnt_addr(2), '1 - 2);
        write_reg(ADDR_OVF_MASK, 32'h2);
        write_reg(ADDR_CFG, cfg_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, ST_ALL_ACTIVE));
        wait_reg_equal(ADDR_OVF_VECT, 32'h6, 20, "both wrap bits");
        wait_intr_level(1'b0, 1'b1, 10, "overflow interrupt to rise");
        read_reg(ADDR_OVF_VECT, val);
        check_eq(val, 32'h6, "wrap vector after rollover");
        // Stop counting and drop the mask
        write_reg(ADDR_CFG, cfg_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, ST_OFF));
        write_reg(ADDR_OVF_MASK, '0);
        wait_intr_level(1'b0, 1'b0, 10, "overflow interrupt to fall");
        read_reg(ADDR_OVF_VECT, val);
        check_eq(val, 32'h6, "wrap vector with mask cleared");
        write_reg(ADDR_CFG, cfg_word(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, ST_OFF));
        wait_reg_equal(ADDR_OVF_VECT, '0, 10, "wrap vector to clear");
        write_reg(ADDR_CFG, '0);
        finish_test("overflow");
    endtask

    task automatic test_quota();
        reg_word_t vals [0:3];
        reg_word_t limits [0:2];
        longint    sum;
        errors_at_start = errors;
        vals   = '{32'd100, 32'd200, 32'd300, 32'd1000};
        limits = '{32'd601, 32'd600, 32'd599};
        write_reg(ADDR_CFG, '0);
        write_reg(ADDR_QUOTA_MASK, 32'h7);
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            write_reg(cnt_addr(k), vals[k]);
            if (k < 3) begin
                sum += vals[k];
            end
        end
        // Masked sum below, equal to and above the limit
        for (int i = 0; i < 3; i++) begin
            write_reg(ADDR_QUOTA_LIMIT, limits[i]);
            repeat (2) @(posedge clk_i);
            @(negedge clk_i);
            check_eq(reg_word_t'(intr_quota_o), reg_word_t'(sum > limits[i]),
                     $sformatf("quota interrupt for limit %0d", limits[i]));
        end
        write_reg(ADDR_CFG, cfg_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, ST_OFF));
        wait_intr_level(1'b1, 1'b0, 10, "quota interrupt to clear");
        repeat (3) @(negedge clk_i);
        check_true(!intr_quota_o, "quota interrupt high during quota soft reset");
        write_reg(ADDR_CFG, '0);
        finish_test("quota");
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------
    initial begin
        rstn_i       = 1'b0;
        reg_we_i     = 1'b0;
        reg_addr_i   = '0;
        reg_wdata_i  = '0;
        events_i     = '0;
        seed         = 82;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_reset();
        test_crossbar();
        test_selftest();
        test_load_softrst();
        test_overflow();
        test_quota();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/pmu_cfg_pkg.sv
source/pmu_map_pkg.sv
source/pmu_control.sv
source/pmu_event_route.sv
source/pmu_counters.sv
source/pmu_overflow.sv
source/pmu_quota.sv
source/pmu_top.sv
test/tb_pmu.sv
